//--- include/cvt_defs.svh
`ifndef CVT_DEFS_SVH
`define CVT_DEFS_SVH

// integer operand width
`define CVT_INT_W 32

// single precision format
`define FP_EXP_W 8
`define FP_FRAC_W 23
`define FP_BIAS 127

// output fifo entries
`define CVT_FIFO_DEPTH 4

`endif

//--- design/fp_pkg.sv
`default_nettype none

`include "cvt_defs.svh"

package fp_pkg;

    // rounding mode codes, 5..7 are unused and fold into RNE
    typedef enum logic [2:0] {
        RNE = 3'd0,  // nearest, ties to even
        RTZ = 3'd1,  // toward zero
        RDN = 3'd2,  // toward -inf
        RUP = 3'd3,  // toward +inf
        RMM = 3'd4   // nearest, ties away
    } round_mode_e;

    // ieee-754 single precision fields, msb first
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exponent;
        logic [`FP_FRAC_W-1:0] fraction;
    } fp32_fields_t;

    // result word, seen either as raw bits or as fields
    typedef union packed {
        logic [`FP_EXP_W+`FP_FRAC_W:0] raw;
        fp32_fields_t                  fields;
    } fp32_word_u;

endpackage

`default_nettype wire

//--- design/cvt_pkg.sv
`default_nettype none

`include "cvt_defs.svh"

package cvt_pkg;

    // request as it arrives from outside
    typedef struct packed {
        logic [`CVT_INT_W-1:0] operand;
        logic                  is_signed;
        fp_pkg::round_mode_e   rm;
    } cvt_req_t;

    // sign/magnitude form after the input register
    typedef struct packed {
        logic                  sign;
        logic [`CVT_INT_W-1:0] magnitude;
        fp_pkg::round_mode_e   rm;
    } cvt_mag_t;

    // normalized operand, exponent already biased
    typedef struct packed {
        logic                   sign;
        logic                   zero;
        logic [`FP_EXP_W-1:0]   exponent;
        logic [`FP_FRAC_W:0]    mant;    // hidden one at the top
        logic                   guard;
        logic                   sticky;
        fp_pkg::round_mode_e    rm;
    } cvt_norm_t;

    typedef struct packed {
        fp_pkg::fp32_word_u result;
        logic               inexact;
    } cvt_rsp_t;

endpackage

`default_nettype wire

//--- design/cvt_in_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cvt_defs.svh"

module cvt_in_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  cvt_pkg::cvt_req_t in_req,
    output logic              mag_valid,
    input  logic              mag_ready,
    output cvt_pkg::cvt_mag_t mag
);

    logic                  neg;
    logic [`CVT_INT_W-1:0] abs_val;
    fp_pkg::round_mode_e   rm_fix;
    logic                  take;

    // register is free when empty or being drained this cycle
    assign in_ready = !mag_valid || mag_ready;
    assign take     = in_valid && in_ready;

    assign neg = in_req.is_signed && in_req.operand[`CVT_INT_W-1];

    // two's complement negate, 0x80000000 stays 0x80000000 = 2^31
    assign abs_val = neg ? (~in_req.operand + 1'b1) : in_req.operand;

    always_comb begin
        if (in_req.rm > fp_pkg::RMM) begin
            rm_fix = fp_pkg::RNE;  // spare codes behave as nearest even
        end else begin
            rm_fix = in_req.rm;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mag_valid <= 1'b0;
        end else if (take) begin
            mag_valid <= 1'b1;
        end else if (mag_ready) begin
            mag_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mag.sign      <= neg;
            mag.magnitude <= abs_val;
            mag.rm        <= rm_fix;
        end
    end

    // upstream must hold the request while it is stalled
    a_req_stable: assert property (@(posedge clk) disable iff (!rst)
        (in_valid && !in_ready) |=> $stable(in_req))
        else $error("in_req changed while waiting for in_ready");

endmodule

`default_nettype wire

//--- design/cvt_normalize.sv
`timescale 1ns/1ps
`default_nettype none

`include "cvt_defs.svh"

module cvt_normalize (
    input  logic               clk,
    input  logic               rst,
    input  logic               mag_valid,
    output logic               mag_ready,
    input  cvt_pkg::cvt_mag_t  mag,
    output logic               norm_valid,
    input  logic               norm_ready,
    output cvt_pkg::cvt_norm_t norm
);

    localparam int IW = `CVT_INT_W;
    localparam int EW = `FP_EXP_W;
    localparam int MW = `FP_FRAC_W + 1;  // mantissa with hidden one
    localparam int LW = $clog2(IW);
    localparam int GB = IW - MW - 1;     // guard bit position after the shift

    logic [LW-1:0]      lead;
    logic [LW-1:0]      sh_amt;
    logic [IW-1:0]      shifted;
    cvt_pkg::cvt_norm_t nxt;
    logic               take;

    assign mag_ready = !norm_valid || norm_ready;
    assign take      = mag_valid && mag_ready;

    // priority search, highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < IW; i++) begin
            if (mag.magnitude[i]) begin
                lead = LW'(i);
            end
        end
    end

    assign sh_amt  = LW'(IW - 1) - lead;
    assign shifted = mag.magnitude << sh_amt;  // leading one lands on the msb

    always_comb begin
        nxt      = '0;
        nxt.sign = mag.sign;
        nxt.rm   = mag.rm;
        if (mag.magnitude == '0) begin
            nxt.zero = 1'b1;  // exponent and mantissa stay clear
        end else begin
            nxt.exponent = EW'(`FP_BIAS) + EW'(lead);
            nxt.mant     = shifted[IW-1 -: MW];
            nxt.guard    = shifted[GB];
            nxt.sticky   = |shifted[GB-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            norm_valid <= 1'b0;
        end else if (take) begin
            norm_valid <= 1'b1;
        end else if (norm_ready) begin
            norm_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            norm <= nxt;
        end
    end

    // a nonzero operand always leaves with the hidden one in place
    a_mant_normal: assert property (@(posedge clk) disable iff (!rst)
        (norm_valid && !norm.zero) |-> norm.mant[MW-1])
        else $error("normalized mantissa lost its leading one");

endmodule

`default_nettype wire

//--- design/cvt_round.sv
`timescale 1ns/1ps
`default_nettype none

`include "cvt_defs.svh"

module cvt_round (
    input  logic               clk,
    input  logic               rst,
    input  logic               norm_valid,
    output logic               norm_ready,
    input  cvt_pkg::cvt_norm_t norm,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output cvt_pkg::cvt_rsp_t  rsp
);

    localparam int EW = `FP_EXP_W;
    localparam int FW = `FP_FRAC_W;
    localparam int MW = FW + 1;

    logic               lost;      // any bit dropped below the mantissa
    logic               inc;
    logic [MW:0]        mant_sum;  // one spare bit for the carry
    logic               carry;
    fp_pkg::fp32_word_u res;
    logic               take;

    assign norm_ready = !rsp_valid || rsp_ready;
    assign take       = norm_valid && norm_ready;

    assign lost = norm.guard | norm.sticky;

    always_comb begin
        case (norm.rm)
            fp_pkg::RTZ: inc = 1'b0;
            fp_pkg::RDN: inc = norm.sign & lost;   // away from zero on negatives
            fp_pkg::RUP: inc = ~norm.sign & lost;
            fp_pkg::RMM: inc = norm.guard;         // ties go up in magnitude
            default: begin
                // nearest even, a tie only bumps an odd mantissa
                inc = norm.guard & (norm.sticky | norm.mant[0]);
            end
        endcase
    end

    assign mant_sum = {1'b0, norm.mant} + {{MW{1'b0}}, inc};
    assign carry    = mant_sum[MW];

    // pack through the field view
    always_comb begin
        if (norm.zero) begin
            res.raw = '0;
        end else begin
            res.fields.sign     = norm.sign;
            res.fields.exponent = norm.exponent + EW'(carry);
            if (carry) begin
                res.fields.fraction = '0;  // 1.111.. rolled over to 10.000..
            end else begin
                res.fields.fraction = mant_sum[FW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rsp_valid <= 1'b0;
        end else if (take) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rsp.result  <= res;
            rsp.inexact <= lost;
        end
    end

    // 32-bit integers span 2^0 .. 2^32 after rounding
    a_exp_range: assert property (@(posedge clk) disable iff (!rst)
        (rsp_valid && rsp.result.raw != '0) |->
            (rsp.result.fields.exponent >= EW'(`FP_BIAS)) &&
            (rsp.result.fields.exponent <= EW'(`FP_BIAS + `CVT_INT_W)))
        else $error("result exponent outside the integer range");

endmodule

`default_nettype wire

//--- design/cvt_out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "cvt_defs.svh"

module cvt_out_fifo #(
    parameter int DEPTH = `CVT_FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_valid,
    output logic              wr_ready,
    input  cvt_pkg::cvt_rsp_t wr_rsp,
    output logic              out_valid,
    input  logic              out_ready,
    output cvt_pkg::cvt_rsp_t out_rsp
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    cvt_pkg::cvt_rsp_t mem [DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [CW-1:0]     count;      // entries still in the buffer
    logic [CW:0]       occupancy;  // buffer plus the head register
    logic              push;
    logic              load;

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign occupancy = {1'b0, count} + {{CW{1'b0}}, out_valid};
    assign wr_ready  = occupancy < (CW+1)'(DEPTH);
    assign push      = wr_valid && wr_ready;
    assign load      = (count != '0) && (!out_valid || out_ready);  // refill head

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (load) begin
                rd_ptr    <= ptr_next(rd_ptr);
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            count <= count + CW'(push) - CW'(load);  // push and pop can coincide
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= wr_rsp;
        if (load) out_rsp <= mem[rd_ptr];
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        occupancy <= (CW+1)'(DEPTH))
        else $error("output fifo holds more than DEPTH entries");

    // an empty buffer has both pointers on the same slot
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst)
        (count == '0) |-> (wr_ptr == rd_ptr))
        else $error("output fifo read pointer passed the write pointer");

endmodule

`default_nettype wire

//--- design/cvt_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cvt_defs.svh"

module cvt_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  cvt_pkg::cvt_req_t in_req,
    output logic              out_valid,
    input  logic              out_ready,
    output cvt_pkg::cvt_rsp_t out_rsp
);

    logic               mag_valid;
    logic               mag_ready;
    cvt_pkg::cvt_mag_t  mag;
    logic               norm_valid;
    logic               norm_ready;
    cvt_pkg::cvt_norm_t norm;
    logic               rsp_valid;
    logic               rsp_ready;  // fifo not full
    cvt_pkg::cvt_rsp_t  rsp;

    cvt_in_stage u_in_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .mag_valid (mag_valid),
        .mag_ready (mag_ready),
        .mag       (mag)
    );

    cvt_normalize u_normalize (
        .clk        (clk),
        .rst        (rst),
        .mag_valid  (mag_valid),
        .mag_ready  (mag_ready),
        .mag        (mag),
        .norm_valid (norm_valid),
        .norm_ready (norm_ready),
        .norm       (norm)
    );

    cvt_round u_round (
        .clk        (clk),
        .rst        (rst),
        .norm_valid (norm_valid),
        .norm_ready (norm_ready),
        .norm       (norm),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp)
    );

    cvt_out_fifo #(
        .DEPTH (`CVT_FIFO_DEPTH)
    ) u_out_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (rsp_valid),
        .wr_ready  (rsp_ready),
        .wr_rsp    (rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

endmodule

`default_nettype wire

//--- tb/tb_cvt_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cvt_defs.svh"

module tb_cvt_top;

    localparam int DEPTH   = `CVT_FIFO_DEPTH;
    localparam int TIMEOUT = 4000;  // roughly 1500 cycles of traffic plus margin

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    cvt_pkg::cvt_req_t in_req;
    logic              out_valid;
    logic              out_ready;
    cvt_pkg::cvt_rsp_t out_rsp;

    cvt_pkg::cvt_rsp_t exp_q [$];  // expected responses with the oldest first
    cvt_pkg::cvt_rsp_t last_rsp;
    logic [31:0]       lcg_state = 32'd48;
    int cycles = 0;
    int tx_cnt = 0;
    int rx_cnt = 0;
    int err_cnt = 0;
    int check_cnt = 0;
    int base_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int accept_cyc = 0;

    cvt_top UUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not complete within %0d cycles", TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // every output transfer matches the oldest outstanding request
    always @(posedge clk) begin
        if (rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("output appeared at %0t with no request outstanding", $time);
            end else begin
                compare_rsp(out_rsp, exp_q.pop_front(), $sformatf("output %0d", rx_cnt));
            end
            last_rsp <= out_rsp;
            rx_cnt   <= rx_cnt + 1;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic cvt_pkg::cvt_req_t make_req(input logic [31:0] op, input logic sgn,
                                                   input logic [2:0] code);
        return {op, sgn, code};
    endfunction

    // magnitude, leading one, 24 kept bits, guard and sticky, then the rounding rule
    function automatic cvt_pkg::cvt_rsp_t reference_convert(input cvt_pkg::cvt_req_t r);
        cvt_pkg::cvt_rsp_t o;
        logic              neg;
        logic [31:0]       m;
        logic [63:0]       ext;
        logic [24:0]       mant;  // extra top bit catches the carry
        logic [7:0]        e;
        logic              g;
        logic              st;
        logic              up;
        int                p;
        o   = '0;
        neg = r.is_signed & r.operand[31];
        m   = neg ? (32'd0 - r.operand) : r.operand;
        if (m == 32'd0) begin
            return o;
        end
        p = 31;
        while (!m[p]) begin
            p--;
        end
        ext  = {m, 32'd0} << (31 - p);  // leading one at bit 63
        mant = {1'b0, ext[63:40]};
        g    = ext[39];
        st   = |ext[38:0];
        case (3'(r.rm))
            3'd1:    up = 1'b0;
            3'd2:    up = neg & (g | st);
            3'd3:    up = ~neg & (g | st);
            3'd4:    up = g;
            default: up = g & (st | mant[0]);  // code 0 and the spare codes
        endcase
        mant = mant + 25'(up);
        e    = 8'(`FP_BIAS + p);
        if (mant[24]) begin
            e = e + 8'd1;  // low 23 bits are already clear after the carry
        end
        o.result.raw = {neg, e, mant[22:0]};
        o.inexact    = g | st;
        return o;
    endfunction

    task automatic check_true(input logic cond, input string what);
        check_cnt++;
        if (!cond) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s", $time, what);
        end
    endtask

    task automatic compare_word(input fp_pkg::fp32_word_u got, input fp_pkg::fp32_word_u want,
                                input string what);
        check_cnt++;
        if (got.raw !== want.raw) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s word %h (exp %0d) expected %h (exp %0d)",
                     $time, what, got.raw, got.fields.exponent, want.raw,
                     want.fields.exponent);
        end
    endtask

    task automatic compare_rsp(input cvt_pkg::cvt_rsp_t got, input cvt_pkg::cvt_rsp_t want,
                               input string what);
        compare_word(got.result, want.result, what);
        check_cnt++;
        if (got.inexact !== want.inexact) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s inexact %b expected %b", $time, what,
                     got.inexact, want.inexact);
        end
    endtask

    // presents one request and returns on the edge that accepts it
    task automatic send_req(input cvt_pkg::cvt_req_t r);
        in_valid <= 1'b1;
        in_req   <= r;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        exp_q.push_back(reference_convert(r));
        accept_cyc = cycles;
        tx_cnt++;
    endtask

    task automatic receive_all();
        while (rx_cnt != tx_cnt) begin
            @(posedge clk);
        end
    endtask

    task automatic convert_check(input cvt_pkg::cvt_req_t r, input logic [31:0] word,
                                 input logic inx, input string what);
        cvt_pkg::cvt_rsp_t want;
        want.result.raw = word;
        want.inexact    = inx;
        send_req(r);
        in_valid <= 1'b0;
        receive_all();
        compare_rsp(last_rsp, want, what);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_cnt == base_errs) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, err_cnt - base_errs);
        end
        base_errs = err_cnt;
    endtask

    task automatic exact_values();
        logic [31:0] extra [5] = '{32'd0, 32'd3, 32'd1000, 32'd12345, 32'h00FF_FFFF};
        logic [31:0] v;
        for (int rm = 0; rm < 5; rm++) begin
            for (int k = 0; k < 30; k++) begin
                v = (k < 25) ? (32'd1 << k) : extra[k - 25];  // 2^0 .. 2^24 first
                send_req(make_req(v, 1'b0, 3'(rm)));
                send_req(make_req(v, 1'b1, 3'(rm)));
                send_req(make_req(32'd0 - v, 1'b1, 3'(rm)));
            end
        end
        in_valid <= 1'b0;
        receive_all();
        finish_test("exact values");
    endtask

    task automatic rounding_modes();
        logic [31:0] v;
        convert_check(make_req(32'h0100_0001, 1'b0, 3'd0), 32'h4B80_0000, 1'b1, "tie RNE");
        convert_check(make_req(32'h0100_0001, 1'b0, 3'd4), 32'h4B80_0001, 1'b1, "tie RMM");
        convert_check(make_req(32'h0100_0003, 1'b0, 3'd0), 32'h4B80_0002, 1'b1, "odd tie RNE");
        convert_check(make_req(32'h0100_0003, 1'b0, 3'd1), 32'h4B80_0001, 1'b1, "odd RTZ");
        convert_check(make_req(32'h0200_0003, 1'b0, 3'd0), 32'h4C00_0001, 1'b1, "over half");
        convert_check(make_req(32'h0100_0001, 1'b0, 3'd3), 32'h4B80_0001, 1'b1, "pos RUP");
        convert_check(make_req(32'hFEFF_FFFF, 1'b1, 3'd2), 32'hCB80_0001, 1'b1, "neg RDN");
        convert_check(make_req(32'hFEFF_FFFF, 1'b1, 3'd3), 32'hCB80_0000, 1'b1, "neg RUP");
        convert_check(make_req(32'hFEFF_FFFF, 1'b1, 3'd1), 32'hCB80_0000, 1'b1, "neg RTZ");
        for (int i = 0; i < 40; i++) begin
            v = lcg_next() | 32'h0100_0000;  // at least 25 significant bits
            send_req(make_req(v, (i % 4) > 1, 3'(i % 5)));
        end
        in_valid <= 1'b0;
        receive_all();
        finish_test("rounding modes");
    endtask

    task automatic edge_operands();
        convert_check(make_req(32'hFFFF_FFFF, 1'b0, 3'd0), 32'h4F80_0000, 1'b1, "max RNE");
        convert_check(make_req(32'hFFFF_FFFF, 1'b0, 3'd3), 32'h4F80_0000, 1'b1, "max RUP");
        convert_check(make_req(32'hFFFF_FFFF, 1'b0, 3'd1), 32'h4F7F_FFFF, 1'b1, "max RTZ");
        convert_check(make_req(32'hFFFF_FFFF, 1'b1, 3'd0), 32'hBF80_0000, 1'b0, "minus one");
        convert_check(make_req(32'h8000_0000, 1'b1, 3'd2), 32'hCF00_0000, 1'b0, "min signed");
        convert_check(make_req(32'h8000_0000, 1'b0, 3'd0), 32'h4F00_0000, 1'b0, "2^31");
        for (int c = 5; c < 8; c++) begin
            convert_check(make_req(32'h0100_0001, 1'b0, 3'(c)), 32'h4B80_0000, 1'b1,
                          $sformatf("code %0d tie", c));
            convert_check(make_req(32'h0100_0003, 1'b0, 3'(c)), 32'h4B80_0002, 1'b1,
                          $sformatf("code %0d odd tie", c));
        end
        finish_test("edge operands");
    endtask

    task automatic streaming();
        int first_acc;
        int last_acc;
        int first_out;
        fork
            begin
                for (int i = 0; i < 64; i++) begin
                    send_req(make_req(lcg_next() >> (i % 32), (i % 2) == 1, 3'(i % 5)));
                    if (i == 0) begin
                        first_acc = accept_cyc;
                    end
                end
                last_acc = accept_cyc;
                in_valid <= 1'b0;
            end
            begin
                @(posedge clk);
                while (!out_valid) begin
                    @(posedge clk);
                end
                first_out = cycles;
            end
        join
        receive_all();
        // out_valid set by an edge is first seen on the following edge
        check_true(first_out - first_acc - 1 == 4,
                   $sformatf("first result %0d cycles after acceptance, expected 4",
                             first_out - first_acc - 1));
        check_true(last_acc - first_acc == 63, "requests not accepted back to back");
        finish_test("streaming");
    endtask

    task automatic back_pressure();
        cvt_pkg::cvt_req_t r;
        int                accepted;
        int                first_stall;
        accepted    = 0;
        first_stall = -1;
        r = make_req(lcg_next(), 1'b1, 3'd0);
        out_ready <= 1'b0;
        in_valid  <= 1'b1;
        in_req    <= r;
        for (int c = 0; c < DEPTH + 12; c++) begin
            @(posedge clk);
            if (in_ready) begin
                exp_q.push_back(reference_convert(r));
                tx_cnt++;
                accepted++;
                r = make_req(lcg_next(), 1'b0, 3'(accepted % 5));
                in_req <= r;
            end else if (first_stall < 0) begin
                first_stall = c;
            end
        end
        check_true(accepted == DEPTH + 3 && first_stall == DEPTH + 3,
                   $sformatf("%0d accepted, stall at %0d, expected %0d", accepted,
                             first_stall, DEPTH + 3));
        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        receive_all();
        finish_test("back pressure");
    endtask

    task automatic random_stream();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] t;
        logic        done;
        done = 1'b0;
        fork
            begin
                for (int i = 0; i < 500; i++) begin
                    a = lcg_next();
                    b = lcg_next();
                    send_req(make_req(a >> b[31:27], b[26], b[25:23]));
                    if (b[22:20] == 3'd0) begin
                        in_valid <= 1'b0;  // occasional idle cycle
                        @(posedge clk);
                    end
                end
                in_valid <= 1'b0;
                done = 1'b1;
            end
            begin
                while (!done) begin
                    @(posedge clk);
                    t = lcg_next();
                    out_ready <= (t[31:30] != 2'b00);  // ready three cycles in four
                end
            end
        join
        out_ready <= 1'b1;
        receive_all();
        finish_test("random stream");
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk        = 1'b0;
        rst       <= 1'b0;
        in_valid  <= 1'b0;
        in_req    <= '0;
        out_ready <= 1'b0;
        repeat (16) @(posedge clk);
        rst       <= 1'b1;
        out_ready <= 1'b1;
        @(posedge clk);
        check_true(in_ready && !out_valid, "in_ready low or out_valid high after reset");
        exact_values();
        rounding_modes();
        edge_operands();
        streaming();
        back_pressure();
        random_stream();
        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
                 check_cnt, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
design/fp_pkg.sv
design/cvt_pkg.sv
design/cvt_in_stage.sv
design/cvt_normalize.sv
design/cvt_round.sv
design/cvt_out_fifo.sv
design/cvt_top.sv
tb/tb_cvt_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the int-to-float converter testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_cvt_top -f compile.f; then
    echo "verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/Vtb_cvt_top); then
    printf '%s\n' "$output"
    echo "simulation exited with an error status"
    exit 1
fi
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
